// File: rename_pkg.sv
////////////////////////////////////////
// Shared widths and records for the rename back end
// Pointer arithmetic assumes GL_DEPTH and
// PHYS_REGS - ARCH_REGS are powers of two
////////////////////////////////////////

package rename_pkg;

    // Sizes
    localparam int XLEN      = 64;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int GL_DEPTH  = 16;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(GL_DEPTH)-1:0]  gl_index_t;
    typedef logic [XLEN-1:0]              xdata_t;

    ////////////////////////////////////////
    // Records between the blocks
    ////////////////////////////////////////

    // Instruction from the front end, we set when rd is written
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      we;
    } dispatch_t;

    // Renamed instruction with its operands
    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t prs1;
        phys_reg_t prs2;
        logic      rdy1;
        logic      rdy2;
        xdata_t    data_rs1;
        xdata_t    data_rs2;
        gl_index_t gl_index;
    } issue_t;

    typedef struct packed {
        logic      valid;
        gl_index_t gl_index;
        phys_reg_t prd;
        xdata_t    result;
    } wb_t;

    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      we;
        xdata_t    result;
    } commit_t;

    // Graduation list entry, we set only when a register was allocated
    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      we;
    } gl_alloc_t;

endpackage

// File: free_list.sv
////////////////////////////////////////
// Free physical register FIFO
// Holds 32..63 in order after reset
// No guard against pop when empty or push
// when full, the caller must respect empty_o
////////////////////////////////////////
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      pop_i,
    input  logic      push_i,
    input  phys_reg_t push_reg_i,
    output phys_reg_t head_reg_o,
    output logic      empty_o
);

    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);

    phys_reg_t        fifo_q [FL_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    // Storage gets the initial free set on reset
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fifo_q[i] <= phys_reg_t'(ARCH_REGS + i);
            end
        end else if (push_i) begin
            fifo_q[tail_q] <= push_reg_i;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_W+1)'(FL_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_reg_o = fifo_q[head_q];
    assign empty_o    = (count_q == '0);

endmodule

// File: rename_stage.sv
////////////////////////////////////////
// Map table, ready bits and issue register
// Issue record is valid for one cycle only,
// there is no back-pressure from issue
////////////////////////////////////////
`timescale 1ns/1ps

module rename_stage
    import rename_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      dispatch_valid_i,
    input  dispatch_t dispatch_i,
    output logic      dispatch_ready_o,
    input  logic      free_empty_i,
    input  phys_reg_t free_reg_i,
    input  logic      gl_full_i,
    input  gl_index_t gl_tail_i,
    output logic      alloc_pop_o,
    output logic      gl_push_o,
    output gl_alloc_t gl_alloc_o,
    input  wb_t       wb_alu_i,
    input  wb_t       wb_mem_i,
    output phys_reg_t prs1_o,
    output phys_reg_t prs2_o,
    input  xdata_t    read_data1_i,
    input  xdata_t    read_data2_i,
    output issue_t    issue_o
);

    phys_reg_t            map_q [ARCH_REGS];
    logic [PHYS_REGS-1:0] ready_q;

    logic      fire;
    logic      alloc;
    phys_reg_t src1_preg;
    phys_reg_t src2_preg;
    phys_reg_t old_preg;
    phys_reg_t new_preg;
    logic      src1_rdy;
    logic      src2_rdy;

    // Issue register
    logic      valid_q;
    arch_reg_t rd_q;
    phys_reg_t prd_q;
    phys_reg_t prs1_q;
    phys_reg_t prs2_q;
    logic      rdy1_q;
    logic      rdy2_q;
    gl_index_t gl_index_q;

    function automatic logic wb_hit(input wb_t wb, input phys_reg_t preg);
        return wb.valid && (wb.prd == preg);
    endfunction

    ////////////////////////////////////////
    // Dispatch and lookup
    ////////////////////////////////////////

    assign dispatch_ready_o = !free_empty_i && !gl_full_i;
    assign fire             = dispatch_valid_i && dispatch_ready_o;
    // x0 is never renamed
    assign alloc            = dispatch_i.we && (dispatch_i.rd != '0);

    assign src1_preg = map_q[dispatch_i.rs1];
    assign src2_preg = map_q[dispatch_i.rs2];
    assign old_preg  = map_q[dispatch_i.rd];
    assign new_preg  = alloc ? free_reg_i : '0;

    // Write-backs of this cycle land in ready_q only at the edge
    assign src1_rdy = ready_q[src1_preg] | wb_hit(wb_alu_i, src1_preg)
                    | wb_hit(wb_mem_i, src1_preg);
    assign src2_rdy = ready_q[src2_preg] | wb_hit(wb_alu_i, src2_preg)
                    | wb_hit(wb_mem_i, src2_preg);

    assign alloc_pop_o = fire && alloc;
    assign gl_push_o   = fire;
    assign gl_alloc_o  = '{rd: dispatch_i.rd, prd: new_preg, old_prd: old_preg, we: alloc};

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
            ready_q <= '1;
        end else begin
            if (wb_alu_i.valid) begin
                ready_q[wb_alu_i.prd] <= 1'b1;
            end
            if (wb_mem_i.valid) begin
                ready_q[wb_mem_i.prd] <= 1'b1;
            end
            // New destination waits for its own write-back
            if (fire && alloc) begin
                map_q[dispatch_i.rd] <= free_reg_i;
                ready_q[free_reg_i]  <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Issue register and snooping
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            rd_q       <= dispatch_i.rd;
            prd_q      <= new_preg;
            prs1_q     <= src1_preg;
            prs2_q     <= src2_preg;
            rdy1_q     <= src1_rdy;
            rdy2_q     <= src2_rdy;
            gl_index_q <= gl_tail_i;
        end
    end

    assign prs1_o = prs1_q;
    assign prs2_o = prs2_q;

    always_comb begin
        issue_o.valid    = valid_q;
        issue_o.rd       = rd_q;
        issue_o.prd      = prd_q;
        issue_o.prs1     = prs1_q;
        issue_o.prs2     = prs2_q;
        issue_o.rdy1     = rdy1_q | wb_hit(wb_alu_i, prs1_q) | wb_hit(wb_mem_i, prs1_q);
        issue_o.rdy2     = rdy2_q | wb_hit(wb_alu_i, prs2_q) | wb_hit(wb_mem_i, prs2_q);
        issue_o.data_rs1 = read_data1_i;
        issue_o.data_rs2 = read_data2_i;
        issue_o.gl_index = gl_index_q;
    end

endmodule

// File: phys_regfile.sv
////////////////////////////////////////
// Physical register file, 2 writes 2 reads
// Register 0 is hardwired to zero
// Both ports must not write the same prd
////////////////////////////////////////
`timescale 1ns/1ps

module phys_regfile
    import rename_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  wb_t       wb_alu_i,
    input  wb_t       wb_mem_i,
    input  phys_reg_t read_addr1_i,
    input  phys_reg_t read_addr2_i,
    output xdata_t    read_data1_o,
    output xdata_t    read_data2_o
);

    xdata_t regs_q [PHYS_REGS];

    // Initial architectural state reads as zero
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (wb_mem_i.valid && (wb_mem_i.prd != '0)) begin
                regs_q[wb_mem_i.prd] <= wb_mem_i.result;
            end
            if (wb_alu_i.valid && (wb_alu_i.prd != '0)) begin
                regs_q[wb_alu_i.prd] <= wb_alu_i.result;
            end
        end
    end

    function automatic xdata_t read_port(input phys_reg_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_alu_i.valid && (wb_alu_i.prd == addr)) begin
            return wb_alu_i.result;
        end else if (wb_mem_i.valid && (wb_mem_i.prd == addr)) begin
            return wb_mem_i.result;
        end
        return regs_q[addr];
    endfunction

    // ALU port wins over the memory port
    always_comb begin
        read_data1_o = read_port(read_addr1_i);
        read_data2_o = read_port(read_addr2_i);
    end

endmodule

// File: graduation_list.sv
////////////////////////////////////////
// In-order retirement queue, 16 entries
// Each gl_index is written back exactly once
// and both ports never share an index
////////////////////////////////////////
`timescale 1ns/1ps

module graduation_list
    import rename_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      push_i,
    input  gl_alloc_t alloc_i,
    output gl_index_t tail_o,
    output logic      full_o,
    input  wb_t       wb_alu_i,
    input  wb_t       wb_mem_i,
    output logic      commit_valid_o,
    input  logic      commit_ready_i,
    output commit_t   commit_o,
    output logic      free_push_o,
    output phys_reg_t free_reg_o
);

    localparam int CNT_W = $clog2(GL_DEPTH) + 1;

    gl_alloc_t           entry_q  [GL_DEPTH];
    xdata_t              result_q [GL_DEPTH];
    logic [GL_DEPTH-1:0] done_q;

    gl_index_t  head_q;
    gl_index_t  tail_q;
    logic [CNT_W-1:0] count_q;
    logic       retire;
    gl_alloc_t  head_entry;

    assign head_entry     = entry_q[head_q];
    assign commit_valid_o = (count_q != '0) && done_q[head_q];
    assign retire         = commit_valid_o && commit_ready_i;

    ////////////////////////////////////////
    // Queue control
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (wb_alu_i.valid) begin
                done_q[wb_alu_i.gl_index] <= 1'b1;
            end
            if (wb_mem_i.valid) begin
                done_q[wb_mem_i.gl_index] <= 1'b1;
            end
            if (push_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({push_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entry_q[tail_q] <= alloc_i;
        end
        if (wb_alu_i.valid) begin
            result_q[wb_alu_i.gl_index] <= wb_alu_i.result;
        end
        if (wb_mem_i.valid) begin
            result_q[wb_mem_i.gl_index] <= wb_mem_i.result;
        end
    end

    assign tail_o = tail_q;
    assign full_o = (count_q == CNT_W'(GL_DEPTH));

    always_comb begin
        commit_o.rd      = head_entry.rd;
        commit_o.prd     = head_entry.prd;
        commit_o.old_prd = head_entry.old_prd;
        commit_o.we      = head_entry.we;
        commit_o.result  = result_q[head_q];
    end

    // Previous mapping goes back only for allocating entries
    assign free_push_o = retire && head_entry.we;
    assign free_reg_o  = head_entry.old_prd;

endmodule

// File: rename_core.sv
////////////////////////////////////////
// Rename and retirement back end
// Write-back ports are always accepted
// Issue has no back-pressure
////////////////////////////////////////
`timescale 1ns/1ps

module rename_core
    import rename_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    // Dispatch from the front end
    input  logic      dispatch_valid_i,
    input  dispatch_t dispatch_i,
    output logic      dispatch_ready_o,
    // Issue to the execution units
    output issue_t    issue_o,
    // Write-back
    input  wb_t       wb_alu_i,
    input  wb_t       wb_mem_i,
    // Retirement
    output logic      commit_valid_o,
    input  logic      commit_ready_i,
    output commit_t   commit_o
);

    logic      free_empty;
    phys_reg_t free_head;
    logic      alloc_pop;
    logic      free_push;
    phys_reg_t free_reg;
    logic      gl_push;
    gl_alloc_t gl_alloc;
    gl_index_t gl_tail;
    logic      gl_full;
    phys_reg_t prs1;
    phys_reg_t prs2;
    xdata_t    read_data1;
    xdata_t    read_data2;

    free_list free_list_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .pop_i      (alloc_pop),
        .push_i     (free_push),
        .push_reg_i (free_reg),
        .head_reg_o (free_head),
        .empty_o    (free_empty)
    );

    rename_stage rename_stage_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .free_empty_i     (free_empty),
        .free_reg_i       (free_head),
        .gl_full_i        (gl_full),
        .gl_tail_i        (gl_tail),
        .alloc_pop_o      (alloc_pop),
        .gl_push_o        (gl_push),
        .gl_alloc_o       (gl_alloc),
        .wb_alu_i         (wb_alu_i),
        .wb_mem_i         (wb_mem_i),
        .prs1_o           (prs1),
        .prs2_o           (prs2),
        .read_data1_i     (read_data1),
        .read_data2_i     (read_data2),
        .issue_o          (issue_o)
    );

    phys_regfile phys_regfile_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb_alu_i     (wb_alu_i),
        .wb_mem_i     (wb_mem_i),
        .read_addr1_i (prs1),
        .read_addr2_i (prs2),
        .read_data1_o (read_data1),
        .read_data2_o (read_data2)
    );

    graduation_list graduation_list_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .push_i         (gl_push),
        .alloc_i        (gl_alloc),
        .tail_o         (gl_tail),
        .full_o         (gl_full),
        .wb_alu_i       (wb_alu_i),
        .wb_mem_i       (wb_mem_i),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_o       (commit_o),
        .free_push_o    (free_push),
        .free_reg_o     (free_reg)
    );

endmodule

// File: tb_clock_gen.sv
////////////////////////////////////////
// Testbench clock and reset source
// Reset is released with an NBA on a rising edge
////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 50,
    parameter int RESET_CYCLES   = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

// File: rename_core_tb.sv
////////////////////////////////////////
// Testbench for the rename back end
// Cycle model of map table, free list, dispatch
// order and architectural state
// At most SEQ_MAX instructions per run
////////////////////////////////////////
`timescale 1ns/1ps

module rename_core_tb
    import rename_pkg::*;
();

    localparam int SEQ_MAX   = 512;
    localparam int WAIT_MAX  = 200;
    localparam int DRAIN_MAX = 5000;

    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      alloc;
        phys_reg_t prd;
        phys_reg_t old_prd;
        phys_reg_t prs1;
        phys_reg_t prs2;
        gl_index_t gl_index;
        logic      done;
        xdata_t    result;
    } inst_t;

    logic      clk;
    logic      rstn;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    issue_t    issue;
    logic      issue_valid;
    wb_t       wb_alu;
    wb_t       wb_mem;
    logic      commit_valid;
    logic      commit_ready;
    commit_t   commit;

    ////////////////////////////////////////
    // Reference model and stimulus state
    ////////////////////////////////////////

    inst_t     recs [SEQ_MAX];
    phys_reg_t map_m [ARCH_REGS];
    phys_reg_t free_m [$];
    int        order_q [$];
    int        wb_pool [$];
    xdata_t    preg_val [PHYS_REGS];
    logic      preg_rdy [PHYS_REGS];
    xdata_t    arch_m [ARCH_REGS];
    gl_index_t tail_m;
    int        seq_n;
    int        issue_seq;
    int        alu_seq;
    int        mem_seq;
    dispatch_t dir_q [$];
    int        disp_left;
    logic      disp_busy;
    logic      alloc_only;
    logic      wb_en;
    int        ready_mode;
    logic      arch_check;
    logic      ready_seen;
    logic [31:0] lfsr;
    int        check_errors;
    int        timeout_errors;
    int        commits;

    tb_clock_gen clock_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    rename_core dut_i (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_i       (dispatch),
        .dispatch_ready_o (dispatch_ready),
        .issue_o          (issue),
        .wb_alu_i         (wb_alu),
        .wb_mem_i         (wb_mem),
        .commit_valid_o   (commit_valid),
        .commit_ready_i   (commit_ready),
        .commit_o         (commit)
    );

    assign issue_valid = issue.valid;

    task automatic report_property(input string msg);
        check_errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    // Stalled head must hold still
    assert property (@(posedge clk) disable iff (!rstn)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
    else report_property("commit_o changed while commit_ready_i was low");

    // One issue record per accepted dispatch
    assert property (@(posedge clk) disable iff (!rstn)
        issue_valid == $past(dispatch_valid && dispatch_ready))
    else report_property("issue_o.valid does not follow the dispatch handshake");

    // Taps 32 22 2 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            check_errors++;
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Check errors: %0d, timeouts: %0d, commits: %0d",
                 check_errors, timeout_errors, commits);
        if (check_errors + timeout_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        timeout_errors++;
        $display("Timeout: %s did not happen within the cycle limit", what);
    endtask

    task automatic queue_dispatch(input int rd, input int rs1, input int rs2, input logic we);
        dispatch_t d;
        d.rd  = arch_reg_t'(rd);
        d.rs1 = arch_reg_t'(rs1);
        d.rs2 = arch_reg_t'(rs2);
        d.we  = we;
        dir_q.push_back(d);
    endtask

    ////////////////////////////////////////
    // Model updates
    ////////////////////////////////////////

    task automatic rename_model(input dispatch_t d);
        int s;
        s = seq_n;
        seq_n++;
        recs[s]         = '0;
        recs[s].rd      = d.rd;
        recs[s].rs1     = d.rs1;
        recs[s].rs2     = d.rs2;
        recs[s].prs1    = map_m[d.rs1];
        recs[s].prs2    = map_m[d.rs2];
        recs[s].old_prd = map_m[d.rd];
        recs[s].alloc   = d.we && (d.rd != '0);
        if (recs[s].alloc) begin
            recs[s].prd         = free_m.pop_front();
            map_m[d.rd]         = recs[s].prd;
            preg_rdy[recs[s].prd] = 1'b0;
        end
        recs[s].gl_index = tail_m;
        tail_m           = tail_m + 1'b1;
        order_q.push_back(s);
        issue_seq = s;
    endtask

    task automatic retire_model();
        int s;
        if (order_q.size() > 0) begin
            s = order_q.pop_front();
            check_value("commit_o.rd", 64'(commit.rd), 64'(recs[s].rd));
            check_value("commit_o.we", 64'(commit.we), 64'(recs[s].alloc));
            check_value("commit_o.prd", 64'(commit.prd), 64'(recs[s].prd));
            check_value("commit_o.old_prd", 64'(commit.old_prd), 64'(recs[s].old_prd));
            check_value("commit_o.result", commit.result, recs[s].result);
            if (recs[s].alloc) begin
                arch_m[recs[s].rd] = recs[s].result;
                free_m.push_back(recs[s].old_prd);
            end
            commits++;
        end
    endtask

    task automatic apply_wb(input int s, input xdata_t result);
        recs[s].done   = 1'b1;
        recs[s].result = result;
        if (recs[s].alloc) begin
            preg_val[recs[s].prd] = result;
            preg_rdy[recs[s].prd] = 1'b1;
        end
    endtask

    // Ready bits already include write-backs of the issue cycle
    task automatic check_issue(input int s);
        check_value("issue_o.rd", 64'(issue.rd), 64'(recs[s].rd));
        check_value("issue_o.prd", 64'(issue.prd), 64'(recs[s].prd));
        check_value("issue_o.prs1", 64'(issue.prs1), 64'(recs[s].prs1));
        check_value("issue_o.prs2", 64'(issue.prs2), 64'(recs[s].prs2));
        check_value("issue_o.gl_index", 64'(issue.gl_index), 64'(recs[s].gl_index));
        check_value("issue_o.rdy1", 64'(issue.rdy1), 64'(preg_rdy[recs[s].prs1]));
        check_value("issue_o.rdy2", 64'(issue.rdy2), 64'(preg_rdy[recs[s].prs2]));
        if (preg_rdy[recs[s].prs1]) begin
            check_value("issue_o.data_rs1", issue.data_rs1, preg_val[recs[s].prs1]);
        end
        if (preg_rdy[recs[s].prs2]) begin
            check_value("issue_o.data_rs2", issue.data_rs2, preg_val[recs[s].prs2]);
        end
        if (arch_check) begin
            check_value("rs1 against retired state", issue.data_rs1, arch_m[recs[s].rs1]);
            check_value("rs2 against retired state", issue.data_rs2, arch_m[recs[s].rs2]);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic pick_wb(output wb_t w, output int s);
        int idx;
        w = '0;
        s = -1;
        if (wb_en && wb_pool.size() > 0 && rand_bits(1) != '0) begin
            idx = int'(rand_bits(6)) % wb_pool.size();
            s   = wb_pool[idx];
            wb_pool.delete(idx);
            w.valid    = 1'b1;
            w.gl_index = recs[s].gl_index;
            w.prd      = recs[s].prd;
            w.result   = rand_bits(XLEN);
        end
    endtask

    task automatic drive_inputs(input logic fire_d);
        dispatch_t d;
        wb_t       w;
        // A refused dispatch stays on the bus
        if (!disp_busy || fire_d) begin
            disp_busy = 1'b0;
            if (dir_q.size() > 0) begin
                d         = dir_q.pop_front();
                disp_busy = 1'b1;
            end else if (disp_left > 0 && rand_bits(2) != '0) begin
                d.rd  = arch_reg_t'(rand_bits(3));
                d.rs1 = arch_reg_t'(rand_bits(3));
                d.rs2 = arch_reg_t'(rand_bits(3));
                d.we  = alloc_only || (rand_bits(2) != '0);
                if (alloc_only && d.rd == '0) begin
                    d.rd = 5'd1;
                end
                disp_busy = 1'b1;
                disp_left--;
            end
            if (disp_busy) begin
                dispatch <= d;
            end
            dispatch_valid <= disp_busy;
        end
        pick_wb(w, alu_seq);
        wb_alu <= w;
        pick_wb(w, mem_seq);
        wb_mem <= w;
        case (ready_mode)
            0:       commit_ready <= 1'b0;
            1:       commit_ready <= 1'b1;
            default: commit_ready <= (rand_bits(2) != '0);
        endcase
    endtask

    // Samples taken at the edge belong to the cycle that just ended
    task automatic run_cycle();
        logic fire_d;
        logic fire_c;
        logic head_done;
        @(posedge clk);
        fire_d     = dispatch_valid && dispatch_ready;
        fire_c     = commit_valid && commit_ready;
        ready_seen = dispatch_ready;
        head_done  = 1'b0;
        if (order_q.size() > 0) begin
            head_done = recs[order_q[0]].done;
        end
        check_value("dispatch_ready_o", 64'(dispatch_ready),
                    64'(free_m.size() > 0 && order_q.size() < GL_DEPTH));
        check_value("commit_valid_o", 64'(commit_valid), 64'(head_done));
        if (fire_c) begin
            retire_model();
        end
        if (wb_alu.valid) begin
            apply_wb(alu_seq, wb_alu.result);
        end
        if (wb_mem.valid) begin
            apply_wb(mem_seq, wb_mem.result);
        end
        check_value("issue_o.valid", 64'(issue.valid), 64'(issue_seq >= 0));
        if (issue_seq >= 0) begin
            check_issue(issue_seq);
            wb_pool.push_back(issue_seq);
            issue_seq = -1;
        end
        if (fire_d) begin
            rename_model(dispatch);
        end
        drive_inputs(fire_d);
    endtask

    task automatic run_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            run_cycle();
        end
    endtask

    task automatic wait_ready(input logic level, input string what);
        int n;
        n = 0;
        run_cycle();
        while (ready_seen != level && n < WAIT_MAX) begin
            run_cycle();
            n++;
        end
        if (ready_seen != level) begin
            timeout_fail(what);
        end
    endtask

    task automatic drain(input string what);
        int n;
        n = 0;
        while ((order_q.size() > 0 || disp_busy || dir_q.size() > 0 || disp_left > 0
                || issue_seq >= 0) && n < DRAIN_MAX) begin
            run_cycle();
            n++;
        end
        if (n == DRAIN_MAX) begin
            timeout_fail(what);
        end
    endtask

    // Test phases in order, a timeout ends the sequence
    task automatic run_sequence();
        int n;
        n = 0;
        while (!rstn && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (!rstn) begin
            timeout_fail("reset release");
            return;
        end
        // First cycle out of reset checks ready high and both valids low
        run_cycle();

        // Producer, consumer before write-back, rd 0 and we low
        queue_dispatch(5, 0, 0, 1'b1);
        queue_dispatch(6, 5, 5, 1'b1);
        queue_dispatch(0, 5, 6, 1'b1);
        queue_dispatch(7, 6, 0, 1'b0);
        run_cycles(8);
        wb_en = 1'b1;
        drain("directed rename drain");
        if (timeout_errors > 0) begin
            return;
        end

        // Random traffic on x0..x7 with random commit stalls
        ready_mode = 2;
        disp_left  = 200;
        drain("random traffic drain");
        if (timeout_errors > 0) begin
            return;
        end

        // Commits held until the graduation list fills
        ready_mode = 0;
        alloc_only = 1'b1;
        disp_left  = 32;
        wait_ready(1'b0, "dispatch_ready_o to drop");
        if (timeout_errors > 0) begin
            return;
        end
        check_value("outstanding entries at stall", 64'(order_q.size()), 64'(GL_DEPTH));
        run_cycles(6);
        ready_mode = 1;
        wait_ready(1'b1, "dispatch_ready_o to rise");
        if (timeout_errors > 0) begin
            return;
        end
        drain("back-pressure drain");
        if (timeout_errors > 0) begin
            return;
        end
        alloc_only = 1'b0;

        // Every register read back against the retired state
        arch_check = 1'b1;
        for (int r = 0; r < ARCH_REGS; r++) begin
            queue_dispatch(0, r, ARCH_REGS - 1 - r, 1'b0);
        end
        drain("architectural read-back drain");
    endtask

    initial begin
        dispatch_valid = 1'b0;
        dispatch       = '0;
        wb_alu         = '0;
        wb_mem         = '0;
        commit_ready   = 1'b0;
        lfsr           = 32'he589;
        check_errors   = 0;
        timeout_errors = 0;
        commits        = 0;
        seq_n          = 0;
        issue_seq      = -1;
        alu_seq        = -1;
        mem_seq        = -1;
        tail_m         = '0;
        disp_left      = 0;
        disp_busy      = 1'b0;
        alloc_only     = 1'b0;
        wb_en          = 1'b0;
        ready_mode     = 1;
        arch_check     = 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i]  = phys_reg_t'(i);
            arch_m[i] = '0;
        end
        for (int i = 0; i < PHYS_REGS; i++) begin
            preg_val[i] = '0;
            preg_rdy[i] = 1'b1;
        end
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
            free_m.push_back(phys_reg_t'(i));
        end

        run_sequence();
        end_run();
    end

endmodule

// File: rename_core.f
rename_pkg.sv
free_list.sv
rename_stage.sv
phys_regfile.sv
graduation_list.sv
rename_core.sv
tb_clock_gen.sv
rename_core_tb.sv

// File: Makefile
SIM      := verilator
TOP      := rename_core_tb
FILELIST := rename_core.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir
PASS_MSG := No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
